// ==== hw/uart_tx_pkg.sv ====
package uart_tx_pkg;

    // ======================================================================
    // Frame constants
    // ======================================================================

    // Data bits per frame, LSB first on the line
    localparam int DATA_BITS = 8;

    // Small default so simulation frames stay short
    localparam int CLKS_PER_BIT_DEFAULT = 8;

    // Counts data bits 0..7
    localparam int BIT_CNT_W = 3;

    // ======================================================================
    // Encodings
    // ======================================================================

    // Controller states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_START = 2'd1,
        ST_DATA  = 2'd2,
        ST_STOP  = 2'd3
    } tx_state_e;

    // Frame datapath opcodes
    typedef enum logic [1:0] {
        OP_HOLD  = 2'd0,   // line and shift register unchanged
        OP_LOAD  = 2'd1,   // latch byte, clear count, start bit
        OP_SHIFT = 2'd2,   // next data bit onto the line
        OP_STOP  = 2'd3    // stop bit
    } frame_op_e;

    // Controller to timer and datapath
    typedef struct packed {
        logic      timer_en;
        frame_op_e op;
    } tx_ctrl_t;

    // Timer and datapath back to controller
    typedef struct packed {
        logic bit_tick;
        logic last_bit;
    } tx_status_t;

endpackage

// ==== hw/uart_tx_timer.sv ====
module uart_tx_timer #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic en,
    output logic tick
);

    // Wide enough to hold CLKS_PER_BIT - 1, at least one bit
    typedef logic [$clog2(CLKS_PER_BIT + 1) - 1:0] cnt_t;

    cnt_t cnt;
    cnt_t cnt_nxt;

    // Wrap at the end of the bit period
    always_comb begin
        if (cnt == cnt_t'(CLKS_PER_BIT - 1)) begin
            cnt_nxt = '0;
        end else begin
            cnt_nxt = cnt + 1'b1;
        end
    end

    // ======================================================================
    // Bit-period counter
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (en) begin
            cnt <= cnt_nxt;
            // Tick is high in the cycle the count wraps
            tick <= (cnt_nxt == cnt_t'(CLKS_PER_BIT - 1));
        end else begin
            // Disabled timer restarts from zero
            cnt  <= '0;
            tick <= 1'b0;
        end
    end

    // One tick per bit period, never back to back
    if (CLKS_PER_BIT > 1) begin : g_tick_chk
        a_tick_single : assert property (
            @(posedge clk) disable iff (rst)
            tick |=> !tick
        );
    end

endmodule

// ==== hw/uart_tx_frame.sv ====
module uart_tx_frame
    import uart_tx_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [DATA_BITS-1:0] din,
    input  frame_op_e            op,
    output logic                 last_bit,
    output logic                 tx
);

    // Byte being sent, shifted right one bit per SHIFT
    logic [DATA_BITS-1:0] shreg;

    // Index of the data bit now on the line
    logic [BIT_CNT_W-1:0] bit_cnt;

    // Set while a data bit, not start or stop, is on the line
    logic data_on;

    // ======================================================================
    // Data shift register
    // ======================================================================
    always_ff @(posedge clk) begin
        case (op)
            OP_LOAD: begin
                shreg <= din;
            end
            OP_SHIFT: begin
                // LSB goes out first
                shreg <= shreg >> 1;
            end
            default: begin
                shreg <= shreg;
            end
        endcase
    end

    // ======================================================================
    // Bit counter and serial output
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            // Line idles high
            tx      <= 1'b1;
            bit_cnt <= '0;
            data_on <= 1'b0;
        end else begin
            case (op)
                OP_LOAD: begin
                    // Start bit
                    tx      <= 1'b0;
                    bit_cnt <= '0;
                    data_on <= 1'b0;
                end
                OP_SHIFT: begin
                    tx      <= shreg[0];
                    data_on <= 1'b1;
                    // First SHIFT puts bit 0 out, no advance yet
                    if (data_on) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                OP_STOP: begin
                    // Stop bit, also the idle level
                    tx      <= 1'b1;
                    data_on <= 1'b0;
                end
                default: begin
                    tx <= tx;
                end
            endcase
        end
    end

    // Eighth data bit on the line
    assign last_bit = data_on && (bit_cnt == BIT_CNT_W'(DATA_BITS - 1));

    // Controller must end the data phase with STOP, not another SHIFT
    a_no_shift_past_last : assert property (
        @(posedge clk) disable iff (rst)
        last_bit |-> (op != OP_SHIFT)
    );

endmodule

// ==== hw/uart_tx_ctrl.sv ====
module uart_tx_ctrl
    import uart_tx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       write_din,
    input  tx_status_t status,
    output tx_ctrl_t   ctrl,
    output logic       tx_ready
);

    tx_state_e state;
    tx_state_e state_nxt;
    tx_ctrl_t  ctrl_nxt;

    // Write taken only while idle and dropped otherwise
    logic accept;

    assign accept = write_din && (state == ST_IDLE);

    // ======================================================================
    // Next-state and opcode decode
    // ======================================================================
    always_comb begin
        state_nxt = state;
        // Opcodes are single-cycle pulses
        ctrl_nxt.op       = OP_HOLD;
        ctrl_nxt.timer_en = ctrl.timer_en;

        case (state)
            ST_IDLE: begin
                if (accept) begin
                    // Latch byte, start bit, start timing
                    state_nxt         = ST_START;
                    ctrl_nxt.op       = OP_LOAD;
                    ctrl_nxt.timer_en = 1'b1;
                end
            end

            ST_START: begin
                // End of start bit, first data bit out
                if (status.bit_tick) begin
                    state_nxt   = ST_DATA;
                    ctrl_nxt.op = OP_SHIFT;
                end
            end

            ST_DATA: begin
                if (status.bit_tick) begin
                    if (status.last_bit) begin
                        // Bit 7 done
                        state_nxt   = ST_STOP;
                        ctrl_nxt.op = OP_STOP;
                    end else begin
                        ctrl_nxt.op = OP_SHIFT;
                    end
                end
            end

            ST_STOP: begin
                // Stop bit period over and the line stays high
                if (status.bit_tick) begin
                    state_nxt         = ST_IDLE;
                    ctrl_nxt.timer_en = 1'b0;
                end
            end

            default: begin
                state_nxt         = ST_IDLE;
                ctrl_nxt.timer_en = 1'b0;
            end
        endcase
    end

    // ======================================================================
    // State and control registers
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_IDLE;
            ctrl.timer_en <= 1'b0;
            ctrl.op       <= OP_HOLD;
        end else begin
            state <= state_nxt;
            ctrl  <= ctrl_nxt;
        end
    end

    // Ready whenever idle
    // falls the cycle after an accepted write
    assign tx_ready = (state == ST_IDLE);

    // LOAD only follows an idle cycle with the timer already stopped
    a_load_from_idle : assert property (
        @(posedge clk) disable iff (rst)
        (ctrl.op == OP_LOAD) |-> $past(state == ST_IDLE && !ctrl.timer_en)
    );

endmodule

// ==== hw/uart_tx_top.sv ====
module uart_tx_top
    import uart_tx_pkg::*;
#(
    parameter int CLKS_PER_BIT = CLKS_PER_BIT_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [DATA_BITS-1:0] din,
    input  logic                 write_din,
    output logic                 tx,
    output logic                 tx_ready
);

    tx_ctrl_t   ctrl;
    tx_status_t status;

    logic bit_tick;
    logic last_bit;

    // Timer and datapath flags into one status word
    assign status.bit_tick = bit_tick;
    assign status.last_bit = last_bit;

    // ======================================================================
    // Controller
    // ======================================================================
    uart_tx_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .write_din (write_din),
        .status    (status),
        .ctrl      (ctrl),
        .tx_ready  (tx_ready)
    );

    // ======================================================================
    // Baud timer
    // ======================================================================
    uart_tx_timer #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_timer (
        .clk  (clk),
        .rst  (rst),
        .en   (ctrl.timer_en),
        .tick (bit_tick)
    );

    // ======================================================================
    // Frame datapath
    // ======================================================================
    uart_tx_frame u_frame (
        .clk      (clk),
        .rst      (rst),
        .din      (din),
        .op       (ctrl.op),
        .last_bit (last_bit),
        .tx       (tx)
    );

endmodule

// ==== sim/uart_tx_tb.sv ====
module uart_tx_tb
    import uart_tx_pkg::*;
();

    // ======================================================================
    // Constants and signals
    // ======================================================================
    localparam int CPB           = CLKS_PER_BIT_DEFAULT;
    localparam int FRAME_BITS    = DATA_BITS + 2;
    localparam int FRAME_CLKS    = FRAME_BITS * CPB;
    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DLY     = 4;
    localparam int RESET_CYCLES  = 16;
    localparam int STREAM_LEN    = 24;
    localparam int READY_TIMEOUT = 2 * FRAME_CLKS;
    localparam int IDLE_TIMEOUT  = 4 * FRAME_CLKS;

    logic                 clk;
    logic                 rst;
    logic [DATA_BITS-1:0] din;
    logic                 write_din;
    logic                 tx;
    logic                 tx_ready;

    // Bytes accepted by the DUT, oldest first
    logic [DATA_BITS-1:0] expected_q[$];
    logic [31:0]          rng_state;

    bit abort;
    int frames_sent;
    int frames_checked;
    int mismatch_cnt;
    int timeout_cnt;
    int other_cnt;

    uart_tx_top #(
        .CLKS_PER_BIT (CPB)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .din       (din),
        .write_din (write_din),
        .tx        (tx),
        .tx_ready  (tx_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ======================================================================
    // Reference model and random source
    // ======================================================================

    // Start 0, data LSB first, stop 1; index 0 goes out first
    function automatic logic [FRAME_BITS-1:0] expected_frame(input logic [DATA_BITS-1:0] b);
        logic [FRAME_BITS-1:0] f;
        f[0] = 1'b0;
        for (int i = 0; i < DATA_BITS; i++) begin
            f[i + 1] = b[i];
        end
        f[FRAME_BITS - 1] = 1'b1;
        return f;
    endfunction

    // 32-bit xorshift, shifts 13/17/5
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ======================================================================
    // Stimulus tasks
    // ======================================================================

    // Line idle and ready for the given number of cycles
    task automatic check_idle(input int cycles);
        for (int c = 0; c < cycles && !abort; c++) begin
            assert (tx === 1'b1) else begin
                mismatch_cnt++;
                $display("FAIL tx: idle got %h expected %h", tx, 1'b1);
            end
            assert (tx_ready === 1'b1) else begin
                mismatch_cnt++;
                $display("FAIL tx_ready: idle got %h expected %h", tx_ready, 1'b1);
            end
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    // One accepted write, then timing checks over the busy period
    // junk adds ignored writes with other data while busy
    task automatic send_byte(input logic [DATA_BITS-1:0] data, input logic junk);
        int guard;
        int low_cnt;
        guard   = 0;
        low_cnt = 0;
        while (!abort && tx_ready !== 1'b1) begin
            if (guard >= READY_TIMEOUT) begin
                $display("Timeout: tx_ready did not return high before the next write");
                timeout_cnt++;
                abort = 1'b1;
            end else begin
                @(posedge clk);
                #DRIVE_DLY;
                guard++;
            end
        end
        if (abort) begin
            return;
        end

        din       = data;
        write_din = 1'b1;
        expected_q.push_back(data);
        frames_sent++;
        @(posedge clk);
        #DRIVE_DLY;
        write_din = 1'b0;

        // Ready drops one cycle after the write, start bit one cycle later
        assert (tx_ready === 1'b0) else begin
            mismatch_cnt++;
            $display("FAIL tx_ready: after write got %h expected %h", tx_ready, 1'b0);
        end
        assert (tx === 1'b1) else begin
            mismatch_cnt++;
            $display("FAIL tx: cycle after write got %h expected %h", tx, 1'b1);
        end

        // Dropped writes near start, middle and last cycle of the busy period
        while (!abort && tx_ready === 1'b0) begin
            low_cnt++;
            if (low_cnt > READY_TIMEOUT) begin
                $display("Timeout: tx_ready stayed low for more than %0d cycles", READY_TIMEOUT);
                timeout_cnt++;
                abort = 1'b1;
            end else begin
                write_din = junk && (low_cnt == 3 || low_cnt == FRAME_CLKS / 2 + 1 ||
                                     low_cnt == FRAME_CLKS);
                if (write_din) begin
                    din = ~data;
                end
                @(posedge clk);
                #DRIVE_DLY;
                if (low_cnt == 1) begin
                    assert (tx === 1'b0) else begin
                        mismatch_cnt++;
                        $display("FAIL tx: start bit got %h expected %h", tx, 1'b0);
                    end
                end
            end
        end
        write_din = 1'b0;

        if (!abort) begin
            assert (low_cnt == FRAME_CLKS) else begin
                mismatch_cnt++;
                $display("FAIL tx_ready: low cycles got %h expected %h", low_cnt, FRAME_CLKS);
            end
        end
    endtask

    task automatic finish_run();
        $display("Frames sent %0d, checked %0d; errors %0d mismatch, %0d timeout, %0d other",
                 frames_sent, frames_checked, mismatch_cnt, timeout_cnt, other_cnt);
        if (mismatch_cnt + timeout_cnt + other_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin : stimulus
        int guard;
        rst            = 1'b1;
        din            = '0;
        write_din      = 1'b0;
        abort          = 1'b0;
        frames_sent    = 0;
        frames_checked = 0;
        mismatch_cnt   = 0;
        timeout_cnt    = 0;
        other_cnt      = 0;
        rng_state      = 32'hc72d_92ea;
        guard          = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        // Quiet line after reset
        check_idle(12);

        // Single frame with dropped writes during it
        send_byte(8'ha5, 1'b1);
        check_idle(6);

        // Back-to-back stream with each write in the cycle ready returns
        send_byte(8'h00, 1'b0);
        for (int i = 0; i < STREAM_LEN && !abort; i++) begin
            rng_state = next_random(rng_state);
            send_byte(rng_state[DATA_BITS-1:0], (i % 7) == 3);
        end
        send_byte(8'hff, 1'b0);

        // Let the sampler finish the last frame
        while (!abort && frames_checked < frames_sent) begin
            if (guard >= FRAME_CLKS) begin
                $display("Timeout: sampler did not finish the last frame");
                timeout_cnt++;
                abort = 1'b1;
            end else begin
                @(posedge clk);
                #DRIVE_DLY;
                guard++;
            end
        end
        check_idle(8);

        finish_run();
    end

    // ======================================================================
    // Serial sampler and compare
    // ======================================================================

    // Called on the first low sample; checks each bit mid-period
    task automatic sample_frame(input int frame_no);
        logic [DATA_BITS-1:0]  exp_byte;
        logic [FRAME_BITS-1:0] exp_bits;
        logic                  got;
        if (expected_q.size() == 0) begin
            $display("Error: frame %0d started on tx with no accepted write pending", frame_no);
            other_cnt++;
            return;
        end
        exp_byte = expected_q.pop_front();
        exp_bits = expected_frame(exp_byte);
        repeat (CPB / 2) @(negedge clk);
        for (int b = 0; b < FRAME_BITS; b++) begin
            if (b > 0) begin
                repeat (CPB) @(negedge clk);
            end
            got = tx;
            assert (got === exp_bits[b]) else begin
                mismatch_cnt++;
                $display("FAIL tx: frame %0d byte %h bit %0d got %h expected %h",
                         frame_no, exp_byte, b, got, exp_bits[b]);
            end
        end
        frames_checked++;
    endtask

    initial begin : sampler
        int   idle_cnt;
        int   frame_no;
        logic prev_tx;
        idle_cnt = 0;
        frame_no = 0;
        prev_tx  = 1'b1;

        // Hold off until reset is released
        while (!abort && rst !== 1'b0) begin
            @(negedge clk);
            idle_cnt++;
            if (idle_cnt > 2 * RESET_CYCLES) begin
                $display("Timeout: reset was never released");
                timeout_cnt++;
                abort = 1'b1;
            end
        end
        idle_cnt = 0;

        // Falling edge of tx marks a start bit
        while (!abort) begin
            @(negedge clk);
            if (prev_tx === 1'b1 && tx === 1'b0) begin
                sample_frame(frame_no);
                frame_no++;
                idle_cnt = 0;
            end else begin
                idle_cnt++;
                if (idle_cnt > IDLE_TIMEOUT) begin
                    $display("Timeout: no start bit on tx for %0d cycles", idle_cnt);
                    timeout_cnt++;
                    abort = 1'b1;
                end
            end
            prev_tx = tx;
        end
    end

endmodule

// ==== sources.f ====
hw/uart_tx_pkg.sv
hw/uart_tx_timer.sv
hw/uart_tx_frame.sv
hw/uart_tx_ctrl.sv
hw/uart_tx_top.sv
sim/uart_tx_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the UART transmitter testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert \
    --top-module uart_tx_tb \
    -Mdir obj_dir \
    -o uart_tx_sim \
    -f sources.f

# A crash or assertion stop also counts as failure
./obj_dir/uart_tx_sim > "$LOG" 2>&1 || { cat "$LOG"; exit 1; }
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation completed without failure"
